// File: hw/mci_pkg.sv
//////////////////////////////
// Shared types for the manageability controller
// Register offsets are byte offsets, one 32-bit word each
// Boot state encoding is visible to firmware in REG_BOOT_STATUS
//////////////////////////////

package mci_pkg;

    localparam int MCI_DATA_W = 32;
    localparam int MCI_ADDR_W = 12;
    localparam int MCI_USER_W = 32;

    ////////////////////////////// Register map
    typedef enum logic [MCI_ADDR_W-1:0] {
        REG_BOOT_GO       = 12'h000,
        REG_CPTRA_BOOT_GO = 12'h004,
        REG_RESET_REQUEST = 12'h008,
        REG_WDT_EN        = 12'h00C,
        REG_WDT_RESTART   = 12'h010,
        REG_WDT_T1_PERIOD = 12'h014,
        REG_WDT_T2_PERIOD = 12'h018,
        REG_WDT_STATUS    = 12'h01C,
        REG_BOOT_STATUS   = 12'h020,
        REG_GENERIC_OUT   = 12'h024,
        REG_GENERIC_IN    = 12'h028
    } mci_reg_addr_e;

    typedef enum logic [3:0] {
        BOOT_IDLE     = 4'd0,
        BOOT_FC_INIT  = 4'd1,
        BOOT_LC_INIT  = 4'd2,
        BOOT_BRKPOINT = 4'd3,
        BOOT_MCU_RUN  = 4'd4,
        BOOT_HALT_REQ = 4'd5,
        BOOT_MCU_RST  = 4'd6
    } mci_boot_state_e;

    ////////////////////////////// Bus payloads
    typedef struct packed {
        logic                  write;
        logic [MCI_ADDR_W-1:0] addr;
        logic [MCI_DATA_W-1:0] wdata;
        logic [MCI_USER_W-1:0] user;
    } mci_req_t;

    typedef struct packed {
        logic [MCI_DATA_W-1:0] rdata;
        logic                  error;
    } mci_rsp_t;

    ////////////////////////////// Block controls
    typedef struct packed {
        logic                  en;
        logic                  restart;
        logic                  service_t1;
        logic [MCI_DATA_W-1:0] t1_period;
        logic [MCI_DATA_W-1:0] t2_period;
    } mci_wdt_ctrl_t;

    typedef struct packed {
        logic t1_timeout;
        logic t2_timeout;
    } mci_wdt_status_t;

    typedef struct packed {
        logic bootfsm_go;
        logic cptra_boot_go;
        logic mcu_rst_req;
    } mci_boot_ctrl_t;

    typedef struct packed {
        mci_boot_state_e state;
        logic            mcu_reset_once;
    } mci_boot_status_t;

endpackage

// File: hw/mci_reg_block.sv
//////////////////////////////
// Register bank behind a valid/ready register bus
// One access in flight; response one cycle after acceptance
// Writes need a user matching one of the two straps
// Reads are open to every user
//////////////////////////////

`timescale 1ns/1ps

module mci_reg_block
    import mci_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_i,

    // Register bus
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  mci_req_t              req_i,
    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i,
    output mci_rsp_t              rsp_o,

    // Privileged users
    input  logic [MCI_USER_W-1:0] strap_soc_config_user_i,
    input  logic [MCI_USER_W-1:0] strap_mcu_lsu_user_i,

    input  logic [MCI_DATA_W-1:0] generic_input_i,
    output logic [MCI_DATA_W-1:0] generic_output_o,

    output mci_wdt_ctrl_t         wdt_ctrl_o,
    input  mci_wdt_status_t       wdt_status_i,
    output mci_boot_ctrl_t        boot_ctrl_o,
    input  mci_boot_status_t      boot_status_i
);

    logic                  rsp_valid_q;
    mci_rsp_t              rsp_q;
    mci_rsp_t              rsp_d;
    logic                  accept;
    logic                  priv;
    logic                  addr_hit;
    logic                  rd_only;
    logic                  wr_en;
    logic [MCI_DATA_W-1:0] rd_data;

    // Stored control bits
    logic                  boot_go_q;
    logic                  cptra_go_q;
    logic                  wdt_en_q;
    logic [MCI_DATA_W-1:0] t1_period_q;
    logic [MCI_DATA_W-1:0] t2_period_q;
    logic [MCI_DATA_W-1:0] gen_out_q;

    // One-cycle pulses
    logic                  restart_q;
    logic                  service_t1_q;
    logic                  mcu_rst_req_q;

    assign req_ready_o = ~rsp_valid_q;
    assign accept      = req_valid_i & req_ready_o;
    assign priv        = (req_i.user == strap_soc_config_user_i) ||
                         (req_i.user == strap_mcu_lsu_user_i);
    assign wr_en       = accept & req_i.write & priv & addr_hit & ~rd_only;

    ////////////////////////////// Decode
    always_comb begin
        rd_data  = '0;
        addr_hit = 1'b1;
        rd_only  = 1'b0;
        case (mci_reg_addr_e'(req_i.addr))
            REG_BOOT_GO:       rd_data[0] = boot_go_q;
            REG_CPTRA_BOOT_GO: rd_data[0] = cptra_go_q;
            REG_RESET_REQUEST: rd_data    = '0;
            REG_WDT_EN:        rd_data[0] = wdt_en_q;
            REG_WDT_RESTART:   rd_data    = '0;
            REG_WDT_T1_PERIOD: rd_data    = t1_period_q;
            REG_WDT_T2_PERIOD: rd_data    = t2_period_q;
            REG_WDT_STATUS:    rd_data[1:0] = {wdt_status_i.t2_timeout, wdt_status_i.t1_timeout};
            REG_BOOT_STATUS: begin
                rd_data[4:0] = {boot_status_i.mcu_reset_once, boot_status_i.state};
                rd_only      = 1'b1;
            end
            REG_GENERIC_OUT:   rd_data    = gen_out_q;
            REG_GENERIC_IN: begin
                rd_data = generic_input_i;
                rd_only = 1'b1;
            end
            default:           addr_hit   = 1'b0;
        endcase
    end

    // Errors and successful writes carry rdata 0
    always_comb begin
        rsp_d.rdata = '0;
        rsp_d.error = 1'b0;
        if (!addr_hit || (req_i.write && (rd_only || !priv))) begin
            rsp_d.error = 1'b1;
        end else if (!req_i.write) begin
            rsp_d.rdata = rd_data;
        end
    end

    ////////////////////////////// Response channel
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rsp_valid_q <= 1'b0;
        end else if (accept) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rsp_q <= rsp_d;
        end
    end

    ////////////////////////////// Register writes
    always_ff @(posedge clk) begin
        if (reset_i) begin
            boot_go_q     <= 1'b0;
            cptra_go_q    <= 1'b0;
            wdt_en_q      <= 1'b0;
            t1_period_q   <= '1;
            t2_period_q   <= '1;
            gen_out_q     <= '0;
            restart_q     <= 1'b0;
            service_t1_q  <= 1'b0;
            mcu_rst_req_q <= 1'b0;
        end else begin
            restart_q     <= wr_en && (req_i.addr == REG_WDT_RESTART) && req_i.wdata[0];
            service_t1_q  <= wr_en && (req_i.addr == REG_WDT_STATUS) && req_i.wdata[0];
            mcu_rst_req_q <= wr_en && (req_i.addr == REG_RESET_REQUEST) && req_i.wdata[0];
            if (wr_en) begin
                case (mci_reg_addr_e'(req_i.addr))
                    REG_BOOT_GO:       boot_go_q   <= req_i.wdata[0];
                    REG_CPTRA_BOOT_GO: cptra_go_q  <= req_i.wdata[0];
                    REG_WDT_EN:        wdt_en_q    <= req_i.wdata[0];
                    REG_WDT_T1_PERIOD: t1_period_q <= req_i.wdata;
                    REG_WDT_T2_PERIOD: t2_period_q <= req_i.wdata;
                    REG_GENERIC_OUT:   gen_out_q   <= req_i.wdata;
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////// Outputs
    assign rsp_valid_o      = rsp_valid_q;
    assign rsp_o            = rsp_q;
    assign generic_output_o = gen_out_q;

    assign wdt_ctrl_o.en         = wdt_en_q;
    assign wdt_ctrl_o.restart    = restart_q;
    assign wdt_ctrl_o.service_t1 = service_t1_q;
    assign wdt_ctrl_o.t1_period  = t1_period_q;
    assign wdt_ctrl_o.t2_period  = t2_period_q;

    assign boot_ctrl_o.bootfsm_go    = boot_go_q;
    assign boot_ctrl_o.cptra_boot_go = cptra_go_q;
    assign boot_ctrl_o.mcu_rst_req   = mcu_rst_req_q;

endmodule

// File: hw/mci_wdt.sv
//////////////////////////////
// Cascaded two-stage watchdog
// Stage 2 only runs while the stage 1 timeout is pending
// Stage 2 timeout and NMI stay set until reset
//////////////////////////////

`timescale 1ns/1ps

module mci_wdt
    import mci_pkg::*;
(
    input  logic            clk,
    input  logic            reset_i,
    input  mci_wdt_ctrl_t   ctrl_i,
    output mci_wdt_status_t status_o,
    output logic            nmi_intr_o
);

    logic [MCI_DATA_W-1:0] cnt1_q;
    logic [MCI_DATA_W-1:0] cnt2_q;
    logic                  t1_timeout_q;
    logic                  t2_timeout_q;

    ////////////////////////////// Counters
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cnt1_q       <= '0;
            cnt2_q       <= '0;
            t1_timeout_q <= 1'b0;
            t2_timeout_q <= 1'b0;
        end else if (ctrl_i.restart || ctrl_i.service_t1) begin
            cnt1_q <= '0;
            cnt2_q <= '0;
            // Only a service acknowledges the first timeout
            if (ctrl_i.service_t1) begin
                t1_timeout_q <= 1'b0;
            end
        end else begin
            // Stage 1
            if (ctrl_i.en && !t1_timeout_q) begin
                if (cnt1_q == ctrl_i.t1_period) begin
                    t1_timeout_q <= 1'b1;
                end else begin
                    cnt1_q <= cnt1_q + 1'b1;
                end
            end

            // Stage 2 armed by an unserviced stage 1 timeout
            if (t1_timeout_q && !t2_timeout_q) begin
                if (cnt2_q == ctrl_i.t2_period) begin
                    t2_timeout_q <= 1'b1;
                end else begin
                    cnt2_q <= cnt2_q + 1'b1;
                end
            end
        end
    end

    ////////////////////////////// Status
    assign status_o.t1_timeout = t1_timeout_q;
    assign status_o.t2_timeout = t2_timeout_q;

    // Fatal timeout goes straight to the MCU NMI
    assign nmi_intr_o = t2_timeout_q;

endmodule

// File: hw/mci_boot_seqr.sv
//////////////////////////////
// Boot and MCU reset sequencer
// Waits on the fuse and lifecycle handshakes, optional breakpoint
// MCU reset hold lasts 2^RST_COUNTER_WIDTH cycles
// Caliptra reset release is one-way until reset
//////////////////////////////

`timescale 1ns/1ps

module mci_boot_seqr
    import mci_pkg::*;
#(
    parameter int RST_COUNTER_WIDTH = 4
) (
    input  logic             clk,
    input  logic             reset_i,
    input  mci_boot_ctrl_t   ctrl_i,
    output mci_boot_status_t status_o,

    input  logic             fc_opt_done_i,
    output logic             fc_opt_init_o,
    input  logic             lc_done_i,
    output logic             lc_init_o,
    input  logic             boot_brkpoint_i,

    output logic             mcu_halt_req_o,
    input  logic             mcu_halt_ack_i,
    output logic             mcu_rst_b_o,
    output logic             cptra_rst_b_o
);

    mci_boot_state_e               state_q;
    mci_boot_state_e               state_d;
    logic [RST_COUNTER_WIDTH-1:0]  rst_cnt_q;
    logic                          rst_cnt_done;
    logic                          mcu_reset_once_q;
    logic                          cptra_rst_b_q;

    // Registered outputs so the reset lines never glitch
    logic                          fc_init_q;
    logic                          lc_init_q;
    logic                          halt_req_q;
    logic                          mcu_rst_b_q;

    assign rst_cnt_done = &rst_cnt_q;

    ////////////////////////////// Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            BOOT_IDLE:     state_d = BOOT_FC_INIT;
            BOOT_FC_INIT:  if (fc_opt_done_i) state_d = BOOT_LC_INIT;
            BOOT_LC_INIT: begin
                if (lc_done_i) begin
                    state_d = boot_brkpoint_i ? BOOT_BRKPOINT : BOOT_MCU_RUN;
                end
            end
            BOOT_BRKPOINT: if (ctrl_i.bootfsm_go) state_d = BOOT_MCU_RUN;
            BOOT_MCU_RUN:  if (ctrl_i.mcu_rst_req) state_d = BOOT_HALT_REQ;
            BOOT_HALT_REQ: if (mcu_halt_ack_i) state_d = BOOT_MCU_RST;
            BOOT_MCU_RST:  if (rst_cnt_done) state_d = BOOT_MCU_RUN;
            default:       state_d = BOOT_IDLE;
        endcase
    end

    ////////////////////////////// State and outputs
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q          <= BOOT_IDLE;
            rst_cnt_q        <= '0;
            mcu_reset_once_q <= 1'b0;
            cptra_rst_b_q    <= 1'b0;
            fc_init_q        <= 1'b0;
            lc_init_q        <= 1'b0;
            halt_req_q       <= 1'b0;
            mcu_rst_b_q      <= 1'b0;
        end else begin
            state_q     <= state_d;
            fc_init_q   <= (state_d == BOOT_FC_INIT);
            lc_init_q   <= (state_d == BOOT_LC_INIT);
            halt_req_q  <= (state_d == BOOT_HALT_REQ);
            // MCU keeps running until it acknowledges the halt
            mcu_rst_b_q <= (state_d == BOOT_MCU_RUN) || (state_d == BOOT_HALT_REQ);

            // Hold counter only runs inside the reset window
            if (state_q == BOOT_MCU_RST) begin
                rst_cnt_q <= rst_cnt_q + 1'b1;
            end else begin
                rst_cnt_q <= '0;
            end

            if (state_q == BOOT_MCU_RST && rst_cnt_done) begin
                mcu_reset_once_q <= 1'b1;
            end

            if (state_q == BOOT_MCU_RUN && ctrl_i.cptra_boot_go) begin
                cptra_rst_b_q <= 1'b1;
            end
        end
    end

    assign fc_opt_init_o  = fc_init_q;
    assign lc_init_o      = lc_init_q;
    assign mcu_halt_req_o = halt_req_q;
    assign mcu_rst_b_o    = mcu_rst_b_q;
    assign cptra_rst_b_o  = cptra_rst_b_q;

    assign status_o.state          = state_q;
    assign status_o.mcu_reset_once = mcu_reset_once_q;

endmodule

// File: hw/mci_top.sv
//////////////////////////////
// Manageability controller top level
// Register bus is valid/ready, single 32-bit accesses
// RST_COUNTER_WIDTH sets the MCU reset hold length
//////////////////////////////

`timescale 1ns/1ps

module mci_top
    import mci_pkg::*;
#(
    parameter int RST_COUNTER_WIDTH = 4
) (
    input  logic                  clk,
    input  logic                  reset_i,

    // Register bus
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  mci_req_t              req_i,
    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i,
    output mci_rsp_t              rsp_o,

    // Straps
    input  logic [MCI_USER_W-1:0] strap_soc_config_user_i,
    input  logic [MCI_USER_W-1:0] strap_mcu_lsu_user_i,

    // Fuse and lifecycle handshakes
    input  logic                  fc_opt_done_i,
    output logic                  fc_opt_init_o,
    input  logic                  lc_done_i,
    output logic                  lc_init_o,
    input  logic                  boot_brkpoint_i,

    // MCU control
    output logic                  mcu_halt_req_o,
    input  logic                  mcu_halt_ack_i,
    output logic                  mcu_rst_b_o,
    output logic                  cptra_rst_b_o,
    output logic                  nmi_intr_o,

    input  logic [MCI_DATA_W-1:0] generic_input_i,
    output logic [MCI_DATA_W-1:0] generic_output_o
);

    mci_wdt_ctrl_t    wdt_ctrl;
    mci_wdt_status_t  wdt_status;
    mci_boot_ctrl_t   boot_ctrl;
    mci_boot_status_t boot_status;

    mci_reg_block i_mci_reg_block (
        .clk,
        .reset_i,
        .req_valid_i,
        .req_ready_o,
        .req_i,
        .rsp_valid_o,
        .rsp_ready_i,
        .rsp_o,
        .strap_soc_config_user_i,
        .strap_mcu_lsu_user_i,
        .generic_input_i,
        .generic_output_o,
        .wdt_ctrl_o    (wdt_ctrl),
        .wdt_status_i  (wdt_status),
        .boot_ctrl_o   (boot_ctrl),
        .boot_status_i (boot_status)
    );

    mci_wdt i_mci_wdt (
        .clk,
        .reset_i,
        .ctrl_i     (wdt_ctrl),
        .status_o   (wdt_status),
        .nmi_intr_o
    );

    mci_boot_seqr #(
        .RST_COUNTER_WIDTH(RST_COUNTER_WIDTH)
    ) i_mci_boot_seqr (
        .clk,
        .reset_i,
        .ctrl_i   (boot_ctrl),
        .status_o (boot_status),
        .fc_opt_done_i,
        .fc_opt_init_o,
        .lc_done_i,
        .lc_init_o,
        .boot_brkpoint_i,
        .mcu_halt_req_o,
        .mcu_halt_ack_i,
        .mcu_rst_b_o,
        .cptra_rst_b_o
    );

endmodule

// File: test/tb_clock_gen.sv
//////////////////////////////
// Testbench clock and reset
// 8 ns clock period
// Reset high for 5 rising edges, released 1 ns after the last one
//////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (5) @(posedge clk_o);
        #1 reset_o = 1'b0;
    end

endmodule

// File: test/mci_tb.sv
//////////////////////////////
// Testbench for the manageability controller
// Inputs change and outputs are sampled 1 ns after the rising edge
// Register table runs after boot with the MCU running
// Response back-pressure comes from the LFSR
//////////////////////////////

`timescale 1ns/1ps

module mci_tb
    import mci_pkg::*;
;

    localparam int          RST_W       = 4;
    localparam int          NUM_ENTRIES = 19;
    localparam int          WDT_T1      = 20;
    localparam int          WDT_T2      = 30;
    localparam int          CYCLE_LIMIT = NUM_ENTRIES * 40 + 2 * (WDT_T1 + WDT_T2) + 200;
    localparam logic [31:0] LFSR_SEED   = 32'd95325;
    localparam logic [31:0] SOC_USER    = 32'h0000_5A01;
    localparam logic [31:0] LSU_USER    = 32'h0000_A502;
    localparam logic [31:0] BAD_USER    = 32'hFFFF_0BAD;

    typedef struct packed {
        mci_req_t req;
        mci_rsp_t exp;
    } vector_t;

    logic                  clk;
    logic                  reset_i;
    logic                  req_valid_i;
    logic                  req_ready_o;
    mci_req_t              req_i;
    logic                  rsp_valid_o;
    logic                  rsp_ready_i;
    mci_rsp_t              rsp_o;
    logic [MCI_USER_W-1:0] strap_soc_config_user_i;
    logic [MCI_USER_W-1:0] strap_mcu_lsu_user_i;
    logic                  fc_opt_done_i;
    logic                  fc_opt_init_o;
    logic                  lc_done_i;
    logic                  lc_init_o;
    logic                  boot_brkpoint_i;
    logic                  mcu_halt_req_o;
    logic                  mcu_halt_ack_i;
    logic                  mcu_rst_b_o;
    logic                  cptra_rst_b_o;
    logic                  nmi_intr_o;
    logic [MCI_DATA_W-1:0] generic_input_i;
    logic [MCI_DATA_W-1:0] generic_output_o;

    vector_t               stim_table [NUM_ENTRIES];
    logic [31:0]           lfsr_state;
    int                    error_count;
    int                    check_count;
    int                    cycle_count;

    tb_clock_gen i_clock_gen (
        .clk_o   (clk),
        .reset_o (reset_i)
    );

    mci_top #(
        .RST_COUNTER_WIDTH(RST_W)
    ) i_mci_top (
        .*
    );

    ////////////////////////////// Random source
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        int k;
        val = '0;
        for (k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    ////////////////////////////// Checks
    task automatic check_rsp(input mci_rsp_t got, input mci_rsp_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH at %0t: %s, got rdata %h error %b, expected rdata %h error %b",
                     $time, what, got.rdata, got.error, exp.rdata, exp.error);
        end
    endtask

    task automatic check_boot_state(input mci_boot_state_e got, input mci_boot_state_e exp,
                                    input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH at %0t: %s, got %s expected %s",
                     $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH at %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input logic [MCI_DATA_W-1:0] got,
                              input logic [MCI_DATA_W-1:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    ////////////////////////////// Bus helpers
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic mci_rsp_t make_rsp(input logic [31:0] rdata, input logic error);
        mci_rsp_t r;
        r.rdata = rdata;
        r.error = error;
        return r;
    endfunction

    function automatic vector_t make_vec(input logic write, input logic [11:0] addr,
                                         input logic [31:0] wdata, input logic [31:0] user,
                                         input logic [31:0] exp_rdata, input logic exp_error);
        vector_t v;
        v.req.write = write;
        v.req.addr  = addr;
        v.req.wdata = wdata;
        v.req.user  = user;
        v.exp       = make_rsp(exp_rdata, exp_error);
        return v;
    endfunction

    // One access, with random response stalls
    task automatic bus_access(input mci_req_t req, output mci_rsp_t rsp);
        logic [31:0] bits;
        mci_rsp_t    first;
        req_valid_i = 1'b1;
        req_i       = req;
        while (!req_ready_o) step();
        step();
        req_valid_i = 1'b0;
        req_i       = '0;
        check_bit(rsp_valid_o, 1'b1, "rsp_valid_o one cycle after acceptance");
        check_bit(req_ready_o, 1'b0, "req_ready_o while response pending");
        first = rsp_o;
        draw_bits(2, bits);
        rsp_ready_i = |bits[1:0];
        while (!(rsp_valid_o && rsp_ready_i)) begin
            step();
            draw_bits(2, bits);
            rsp_ready_i = |bits[1:0];
        end
        rsp = rsp_o;
        check_rsp(rsp, first, "response held under back-pressure");
        step();
        rsp_ready_i = 1'b0;
    endtask

    task automatic write_reg(input logic [11:0] addr, input logic [31:0] data,
                             output mci_rsp_t rsp);
        mci_req_t req;
        req.write = 1'b1;
        req.addr  = addr;
        req.wdata = data;
        req.user  = SOC_USER;
        bus_access(req, rsp);
    endtask

    task automatic read_reg(input logic [11:0] addr, output mci_rsp_t rsp);
        mci_req_t req;
        req.write = 1'b0;
        req.addr  = addr;
        req.wdata = '0;
        req.user  = LSU_USER;
        bus_access(req, rsp);
    endtask

    ////////////////////////////// Stimulus table
    task automatic build_table();
        logic [31:0] g0;
        logic [31:0] g1;
        logic [31:0] g2;
        draw_bits(32, g0);
        draw_bits(32, g1);
        draw_bits(32, g2);
        stim_table[0]  = make_vec(1, REG_GENERIC_OUT, g0, SOC_USER, 0, 0);
        stim_table[1]  = make_vec(0, REG_GENERIC_OUT, 0, SOC_USER, g0, 0);
        stim_table[2]  = make_vec(1, REG_GENERIC_OUT, g1, LSU_USER, 0, 0);
        stim_table[3]  = make_vec(0, REG_GENERIC_OUT, 0, BAD_USER, g1, 0);
        stim_table[4]  = make_vec(1, REG_GENERIC_OUT, g2, BAD_USER, 0, 1);
        stim_table[5]  = make_vec(0, REG_GENERIC_OUT, 0, SOC_USER, g1, 0);
        stim_table[6]  = make_vec(0, REG_GENERIC_IN, 0, BAD_USER, generic_input_i, 0);
        stim_table[7]  = make_vec(1, REG_GENERIC_IN, g2, SOC_USER, 0, 1);
        stim_table[8]  = make_vec(0, 12'h02C, 0, SOC_USER, 0, 1);
        stim_table[9]  = make_vec(1, 12'h0FC, g2, SOC_USER, 0, 1);
        stim_table[10] = make_vec(1, REG_BOOT_STATUS, 32'h1F, SOC_USER, 0, 1);
        stim_table[11] = make_vec(0, REG_BOOT_STATUS, 0, SOC_USER, 32'(BOOT_MCU_RUN), 0);
        stim_table[12] = make_vec(1, REG_CPTRA_BOOT_GO, 1, BAD_USER, 0, 1);
        stim_table[13] = make_vec(1, REG_CPTRA_BOOT_GO, 1, SOC_USER, 0, 0);
        stim_table[14] = make_vec(0, REG_CPTRA_BOOT_GO, 0, LSU_USER, 1, 0);
        stim_table[15] = make_vec(1, REG_WDT_T1_PERIOD, WDT_T1, SOC_USER, 0, 0);
        stim_table[16] = make_vec(1, REG_WDT_T2_PERIOD, WDT_T2, LSU_USER, 0, 0);
        stim_table[17] = make_vec(0, REG_WDT_T1_PERIOD, 0, SOC_USER, WDT_T1, 0);
        stim_table[18] = make_vec(0, REG_WDT_T2_PERIOD, 0, SOC_USER, WDT_T2, 0);
    endtask

    ////////////////////////////// Cycle limit
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run exceeded its cycle limit of %0d cycles", CYCLE_LIMIT);
        $display("Something failed");
        $finish;
    end

    ////////////////////////////// Main sequence
    initial begin
        mci_rsp_t    rsp;
        logic [31:0] gen_exp;
        logic        cptra_exp;
        int          hold_cycles;
        int          i;

        error_count             = 0;
        check_count             = 0;
        lfsr_state              = LFSR_SEED;
        req_valid_i             = 1'b0;
        req_i                   = '0;
        rsp_ready_i             = 1'b0;
        strap_soc_config_user_i = SOC_USER;
        strap_mcu_lsu_user_i    = LSU_USER;
        fc_opt_done_i           = 1'b0;
        lc_done_i               = 1'b0;
        boot_brkpoint_i         = 1'b1;
        mcu_halt_ack_i          = 1'b0;
        draw_bits(32, generic_input_i);
        gen_exp                 = '0;
        cptra_exp               = 1'b0;

        @(negedge reset_i);
        check_bit(req_ready_o, 1'b1, "req_ready_o after reset");
        check_bit(rsp_valid_o, 1'b0, "rsp_valid_o after reset");
        check_bit(fc_opt_init_o, 1'b0, "fc_opt_init_o after reset");
        check_bit(lc_init_o, 1'b0, "lc_init_o after reset");
        check_bit(mcu_rst_b_o, 1'b0, "mcu_rst_b_o after reset");
        check_bit(cptra_rst_b_o, 1'b0, "cptra_rst_b_o after reset");
        check_bit(mcu_halt_req_o, 1'b0, "mcu_halt_req_o after reset");
        check_bit(nmi_intr_o, 1'b0, "nmi_intr_o after reset");

        // Boot handshakes, stopping at the breakpoint
        while (!fc_opt_init_o) step();
        fc_opt_done_i = 1'b1;
        step();
        fc_opt_done_i = 1'b0;
        while (!lc_init_o) step();
        check_bit(fc_opt_init_o, 1'b0, "fc_opt_init_o after fuse init done");
        lc_done_i = 1'b1;
        step();
        lc_done_i = 1'b0;
        check_bit(lc_init_o, 1'b0, "lc_init_o after lifecycle init done");
        step();
        check_bit(mcu_rst_b_o, 1'b0, "mcu_rst_b_o at breakpoint");
        read_reg(REG_BOOT_STATUS, rsp);
        check_boot_state(mci_boot_state_e'(rsp.rdata[3:0]), BOOT_BRKPOINT,
                         "boot state at breakpoint");
        write_reg(REG_BOOT_GO, 32'h1, rsp);
        check_rsp(rsp, make_rsp(0, 0), "write of REG_BOOT_GO");
        check_bit(mcu_rst_b_o, 1'b1, "mcu_rst_b_o after boot go");
        read_reg(REG_BOOT_STATUS, rsp);
        check_boot_state(mci_boot_state_e'(rsp.rdata[3:0]), BOOT_MCU_RUN,
                         "boot state after go");

        // Register access and access rules
        build_table();
        for (i = 0; i < NUM_ENTRIES; i++) begin
            bus_access(stim_table[i].req, rsp);
            check_rsp(rsp, stim_table[i].exp, $sformatf("table entry %0d", i));
            if (stim_table[i].req.write && !stim_table[i].exp.error) begin
                if (stim_table[i].req.addr == REG_GENERIC_OUT) begin
                    gen_exp = stim_table[i].req.wdata;
                end
                if (stim_table[i].req.addr == REG_CPTRA_BOOT_GO && stim_table[i].req.wdata[0]) begin
                    cptra_exp = 1'b1;
                end
            end
            if (stim_table[i].req.addr == REG_GENERIC_OUT) begin
                check_word(generic_output_o, gen_exp,
                           $sformatf("generic_output_o, entry %0d", i));
            end
            check_bit(cptra_rst_b_o, cptra_exp, $sformatf("cptra_rst_b_o, entry %0d", i));
        end

        // Watchdog, first timeout serviced once, then left to escalate
        check_bit(nmi_intr_o, 1'b0, "nmi_intr_o before watchdog enable");
        write_reg(REG_WDT_EN, 32'h1, rsp);
        check_rsp(rsp, make_rsp(0, 0), "write of REG_WDT_EN");
        read_reg(REG_WDT_STATUS, rsp);
        while (!rsp.rdata[0]) read_reg(REG_WDT_STATUS, rsp);
        check_bit(rsp.rdata[1], 1'b0, "t2_timeout at first t1_timeout");
        write_reg(REG_WDT_STATUS, 32'h1, rsp);
        check_rsp(rsp, make_rsp(0, 0), "service of timer 1");
        read_reg(REG_WDT_STATUS, rsp);
        check_rsp(rsp, make_rsp(0, 0), "watchdog status after service");
        check_bit(nmi_intr_o, 1'b0, "nmi_intr_o after service");
        read_reg(REG_WDT_STATUS, rsp);
        while (!rsp.rdata[1]) read_reg(REG_WDT_STATUS, rsp);
        check_rsp(rsp, make_rsp(32'h3, 0), "watchdog status at second timeout");
        check_bit(nmi_intr_o, 1'b1, "nmi_intr_o at second timeout");
        repeat (10) step();
        read_reg(REG_WDT_STATUS, rsp);
        check_rsp(rsp, make_rsp(32'h3, 0), "watchdog status stays set");
        check_bit(nmi_intr_o, 1'b1, "nmi_intr_o stays set");

        // MCU reset request through halt handshake
        write_reg(REG_RESET_REQUEST, 32'h1, rsp);
        check_rsp(rsp, make_rsp(0, 0), "write of REG_RESET_REQUEST");
        while (!mcu_halt_req_o) step();
        check_bit(mcu_rst_b_o, 1'b1, "mcu_rst_b_o while halt requested");
        mcu_halt_ack_i = 1'b1;
        step();
        mcu_halt_ack_i = 1'b0;
        hold_cycles = 0;
        while (!mcu_rst_b_o) begin
            hold_cycles++;
            step();
        end
        check_word(hold_cycles, 1 << RST_W, "MCU reset hold length in cycles");
        check_bit(mcu_halt_req_o, 1'b0, "mcu_halt_req_o after reset hold");
        read_reg(REG_RESET_REQUEST, rsp);
        check_rsp(rsp, make_rsp(0, 0), "read of REG_RESET_REQUEST");
        read_reg(REG_BOOT_STATUS, rsp);
        check_boot_state(mci_boot_state_e'(rsp.rdata[3:0]), BOOT_MCU_RUN,
                         "boot state after MCU reset");
        check_bit(rsp.rdata[4], 1'b1, "mcu_reset_once after MCU reset");
        check_bit(cptra_rst_b_o, 1'b1, "cptra_rst_b_o at end of run");

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: mci_lite.f
hw/mci_pkg.sv
hw/mci_reg_block.sv
hw/mci_wdt.sv
hw/mci_boot_seqr.sv
hw/mci_top.sv
test/tb_clock_gen.sv
test/mci_tb.sv
